// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= sim passed

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
+incdir+.
icache_addr_pkg.sv
icache_data_pkg.sv
icache_tag_store.sv
icache_victim_ring.sv
icache_data_ram.sv
icache_resp_fsm.sv
icache_top.sv
icache_props.sv
tb_icache.sv

// ==== icache_addr_pkg.sv ====
`default_nettype none
`include "icache_consts.svh"

package icache_addr_pkg;

	typedef logic [`ICACHE_ADDR_W-1:0]     addr_t;
	typedef logic [`ICACHE_TAG_W-1:0]      tag_t;      // Bits 63..10
	typedef logic [`ICACHE_INDEX_W-1:0]    index_t;    // Bits 9..4
	typedef logic [`ICACHE_OFFSET_W-3:0]   word_sel_t; // Bits 3..2

	function automatic tag_t addr_tag(input addr_t a);
		return a[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
	endfunction

	function automatic index_t addr_index(input addr_t a);
		return a[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
	endfunction

	function automatic word_sel_t addr_word(input addr_t a);
		return a[`ICACHE_OFFSET_W-1:2]; // Byte bits 1..0 are dropped
	endfunction

endpackage

`default_nettype wire

// ==== icache_consts.svh ====
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// Fetch side
`define ICACHE_ADDR_W   64 // Fetch address width

// Organisation
`define ICACHE_WAYS     4  // Four-way set associative
`define ICACHE_SETS     64
`define ICACHE_INDEX_W  6  // log2 of the set count
`define ICACHE_OFFSET_W 4  // 16-byte lines

// Tag is whatever is left above index and offset
`define ICACHE_TAG_W    (`ICACHE_ADDR_W - `ICACHE_INDEX_W - `ICACHE_OFFSET_W)

// Payload
`define ICACHE_LINE_W   128 // Four instructions per line
`define ICACHE_INST_W   32

`endif

// ==== icache_data_pkg.sv ====
`default_nettype none
`include "icache_consts.svh"

package icache_data_pkg;

	typedef logic [`ICACHE_LINE_W-1:0] line_t;    // Instruction k at bit 32k
	typedef logic [`ICACHE_INST_W-1:0] inst_t;
	typedef logic [`ICACHE_WAYS-1:0]   way_vec_t; // Hit vector or victim one-hot

	// Picks one instruction out of a line
	function automatic inst_t line_word(
		input line_t                      line,
		input icache_addr_pkg::word_sel_t sel
	);
		return line[sel * `ICACHE_INST_W +: `ICACHE_INST_W];
	endfunction

endpackage

`default_nettype wire

// ==== icache_data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "icache_consts.svh"

module icache_data_ram (
	input  logic                    clk,
	input  logic                    en,
	input  logic                    we,
	input  icache_addr_pkg::index_t index,
	input  icache_data_pkg::line_t  wdata,
	output icache_data_pkg::line_t  rdata
);

	icache_data_pkg::line_t mem [`ICACHE_SETS];

	// Single port, write has priority over read
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[index] <= wdata;
			end else begin
				rdata <= mem[index]; // Valid the cycle after the address
			end
		end
	end

endmodule

`default_nettype wire

// ==== icache_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_props (
	input logic                      clk,
	input logic                      rst,
	input logic                      valid,
	input logic                      ready_id,
	input logic                      mem_req,
	input icache_data_pkg::way_vec_t hit,
	input icache_data_pkg::way_vec_t victim
);

	int unsigned req_errs    = 0; // Failure counts
	int unsigned victim_errs = 0;
	int unsigned hit_errs    = 0;

	// Refill only for an accepted lookup
	a_req_accepted: assert property (@(posedge clk) disable iff (rst)
		mem_req |-> (valid && ready_id))
	else begin
		$error("mem_req without valid and ready_id");
		req_errs++;
	end

	a_victim_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(victim))
	else begin
		$error("victim ring lost its one-hot state");
		victim_errs++;
	end

	// A line lives in at most one way
	a_hit_onehot0: assert property (@(posedge clk) disable iff (rst) $onehot0(hit))
	else begin
		$error("more than one way hit");
		hit_errs++;
	end

endmodule

bind icache_top icache_props u_icache_props (
	.clk      (clk),
	.rst      (rst),
	.valid    (valid),
	.ready_id (ready_id),
	.mem_req  (mem_req),
	.hit      (hit),
	.victim   (victim)
);

`default_nettype wire

// ==== icache_resp_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "icache_consts.svh"

module icache_resp_fsm (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      valid,
	input  logic                      flush,
	input  logic                      ready_id,
	input  icache_addr_pkg::addr_t    addr,
	input  icache_data_pkg::way_vec_t hit,
	input  icache_data_pkg::way_vec_t victim,
	input  icache_data_pkg::line_t    mem_line,
	input  icache_data_pkg::line_t    way_data0,
	input  icache_data_pkg::line_t    way_data1,
	input  icache_data_pkg::line_t    way_data2,
	input  icache_data_pkg::line_t    way_data3,
	output logic                      fill,
	output logic                      advance,
	output logic                      mem_req,
	output icache_addr_pkg::addr_t    mem_addr,
	output icache_addr_pkg::index_t   ram_index,
	output icache_data_pkg::way_vec_t ram_en,
	output icache_data_pkg::inst_t    inst,
	output logic                      ready
);

	typedef enum logic [1:0] {EMPTY, HIT_OUT, MISS_OUT} state_t;

	state_t                     state;
	logic                       accept;
	logic                       miss;
	icache_data_pkg::way_vec_t  hit_q;
	icache_addr_pkg::word_sel_t word_q;
	icache_addr_pkg::index_t    index_q;
	icache_data_pkg::line_t     line_q;
	icache_data_pkg::line_t     out_line;

	assign accept  = valid && ready_id && !flush;
	assign miss    = accept && (hit == '0);
	assign fill    = miss; // Line comes back in the same cycle
	assign mem_req = miss;
	assign advance = ready_id && !flush;

	assign mem_addr = {addr[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};

	// Stalled, the RAM keeps rereading the entry being shown
	assign ram_index = ready_id ? icache_addr_pkg::addr_index(addr) : index_q;

	always_comb begin
		if (accept) begin
			ram_en = miss ? victim : hit;
		end else if (!ready_id) begin
			ram_en = hit_q;
		end else begin
			ram_en = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= EMPTY;
			hit_q   <= '0;
			word_q  <= '0;
			index_q <= '0;
			line_q  <= '0;
		end else if (ready_id) begin
			if (flush) begin
				state   <= EMPTY; // Drop whatever was in flight
				hit_q   <= '0;
				word_q  <= '0;
				index_q <= '0;
				line_q  <= '0;
			end else begin
				hit_q   <= accept ? hit : '0;
				word_q  <= icache_addr_pkg::addr_word(addr);
				index_q <= icache_addr_pkg::addr_index(addr);
				if (miss) begin
					line_q <= mem_line; // Bypass so the miss needs no RAM read
				end
				if (!valid) begin
					state <= EMPTY;
				end else if (miss) begin
					state <= MISS_OUT;
				end else begin
					state <= HIT_OUT;
				end
			end
		end
	end

	// Way mux
	always_comb begin
		out_line = line_q;
		if (state == HIT_OUT) begin
			case (hit_q)
				4'b0001: out_line = way_data0;
				4'b0010: out_line = way_data1;
				4'b0100: out_line = way_data2;
				4'b1000: out_line = way_data3;
				default: out_line = line_q;
			endcase
		end
	end

	assign inst  = icache_data_pkg::line_word(out_line, word_q);
	assign ready = (state != EMPTY);

endmodule

`default_nettype wire

// ==== icache_tag_store.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "icache_consts.svh"

module icache_tag_store (
	input  logic                      clk,
	input  logic                      rst,
	input  icache_addr_pkg::addr_t    addr,
	input  logic                      fill,
	input  icache_data_pkg::way_vec_t victim,
	output icache_data_pkg::way_vec_t hit
);

	icache_addr_pkg::index_t set_idx;
	icache_addr_pkg::tag_t   addr_tag;

	assign set_idx  = icache_addr_pkg::addr_index(addr);
	assign addr_tag = icache_addr_pkg::addr_tag(addr);

	// One tag array and one valid vector per way
	for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
		icache_addr_pkg::tag_t   tag_q [`ICACHE_SETS];
		logic [`ICACHE_SETS-1:0] valid_q;

		always_ff @(posedge clk) begin
			if (rst) begin
				valid_q <= '0; // Cold cache
			end else if (fill && victim[w]) begin
				valid_q[set_idx] <= 1'b1;
			end
		end

		// Victim tag written with the fill
		always_ff @(posedge clk) begin
			if (fill && victim[w]) begin
				tag_q[set_idx] <= addr_tag;
			end
		end

		// Same-cycle lookup
		assign hit[w] = valid_q[set_idx] && (tag_q[set_idx] == addr_tag);
	end

endmodule

`default_nettype wire

// ==== icache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_top (
	input  logic                   clk,
	input  logic                   rst,
	input  icache_addr_pkg::addr_t addr,
	input  logic                   valid,
	input  logic                   flush,
	input  logic                   ready_id,
	input  icache_data_pkg::line_t mem_line,
	output logic                   mem_req,
	output icache_addr_pkg::addr_t mem_addr,
	output icache_data_pkg::inst_t inst,
	output logic                   ready
);

	icache_data_pkg::way_vec_t hit;
	icache_data_pkg::way_vec_t victim;
	icache_data_pkg::way_vec_t ram_en;
	icache_addr_pkg::index_t   ram_index;
	icache_data_pkg::line_t    way_data0;
	icache_data_pkg::line_t    way_data1;
	icache_data_pkg::line_t    way_data2;
	icache_data_pkg::line_t    way_data3;
	logic                      fill;
	logic                      advance;

	icache_tag_store u_tag_store (
		.clk    (clk),
		.rst    (rst),
		.addr   (addr),
		.fill   (fill),
		.victim (victim),
		.hit    (hit)
	);

	icache_victim_ring u_victim_ring (
		.clk     (clk),
		.rst     (rst),
		.advance (advance),
		.victim  (victim)
	);

	// All ways share index, write strobe and fill data
	icache_data_ram u_way0 (
		.clk   (clk),
		.en    (ram_en[0]),
		.we    (fill),
		.index (ram_index),
		.wdata (mem_line),
		.rdata (way_data0)
	);

	icache_data_ram u_way1 (
		.clk   (clk),
		.en    (ram_en[1]),
		.we    (fill),
		.index (ram_index),
		.wdata (mem_line),
		.rdata (way_data1)
	);

	icache_data_ram u_way2 (
		.clk   (clk),
		.en    (ram_en[2]),
		.we    (fill),
		.index (ram_index),
		.wdata (mem_line),
		.rdata (way_data2)
	);

	icache_data_ram u_way3 (
		.clk   (clk),
		.en    (ram_en[3]),
		.we    (fill),
		.index (ram_index),
		.wdata (mem_line),
		.rdata (way_data3)
	);

	icache_resp_fsm u_resp_fsm (
		.clk       (clk),
		.rst       (rst),
		.valid     (valid),
		.flush     (flush),
		.ready_id  (ready_id),
		.addr      (addr),
		.hit       (hit),
		.victim    (victim),
		.mem_line  (mem_line),
		.way_data0 (way_data0),
		.way_data1 (way_data1),
		.way_data2 (way_data2),
		.way_data3 (way_data3),
		.fill      (fill),
		.advance   (advance),
		.mem_req   (mem_req),
		.mem_addr  (mem_addr),
		.ram_index (ram_index),
		.ram_en    (ram_en),
		.inst      (inst),
		.ready     (ready)
	);

endmodule

`default_nettype wire

// ==== icache_victim_ring.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "icache_consts.svh"

module icache_victim_ring (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      advance,
	output icache_data_pkg::way_vec_t victim
);

	// Single hot bit walks 0 -> 1 -> 2 -> 3 -> 0
	always_ff @(posedge clk) begin
		if (rst) begin
			victim <= icache_data_pkg::way_vec_t'(1); // Start at way 0
		end else if (advance) begin
			victim <= {victim[`ICACHE_WAYS-2:0], victim[`ICACHE_WAYS-1]};
		end
	end

endmodule

`default_nettype wire

// ==== tb_icache.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "icache_consts.svh"

module tb_icache;

	localparam int          TIMEOUT_CYCLES = 3000;
	localparam int          RANDOM_CYCLES  = 400;
	localparam logic [31:0] WORD_KEY       = 32'h5a5a_c3c3; // Memory content scramble

	logic                   clk;
	logic                   rst;
	icache_addr_pkg::addr_t addr;
	logic                   valid;
	logic                   flush;
	logic                   ready_id;
	icache_data_pkg::line_t mem_line;
	logic                   mem_req;
	icache_addr_pkg::addr_t mem_addr;
	icache_data_pkg::inst_t inst;
	logic                   ready;

	integer seed;

	// Reference model of the tag side
	icache_addr_pkg::tag_t   model_tag [`ICACHE_WAYS][`ICACHE_SETS];
	logic                    model_valid [`ICACHE_WAYS][`ICACHE_SETS];
	int                      model_ring;
	logic                    exp_ready;
	icache_data_pkg::inst_t  exp_inst;
	int                      hit_count;
	int                      miss_count;
	icache_addr_pkg::tag_t   tag_pool [6];
	icache_addr_pkg::index_t index_pool [3];

	icache_top u_icache_top (
		.clk      (clk),
		.rst      (rst),
		.addr     (addr),
		.valid    (valid),
		.flush    (flush),
		.ready_id (ready_id),
		.mem_line (mem_line),
		.mem_req  (mem_req),
		.mem_addr (mem_addr),
		.inst     (inst),
		.ready    (ready)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// Backing memory answers in the same cycle
	function automatic icache_data_pkg::line_t line_at(input icache_addr_pkg::addr_t a);
		icache_data_pkg::line_t line;
		logic [31:0]            base;
		base = {a[31:4], 4'h0};
		for (int k = 0; k < 4; k++) begin
			line[32*k +: 32] = (base + 32'(4 * k)) ^ WORD_KEY;
		end
		return line;
	endfunction

	assign mem_line = line_at(mem_addr);

	function automatic logic [31:0] word_at(input icache_addr_pkg::addr_t a);
		return {a[31:2], 2'b00} ^ WORD_KEY; // Scrambled instruction byte address
	endfunction

	// Way holding the line of a, or -1
	function automatic int model_way(input icache_addr_pkg::addr_t a);
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (model_valid[w][a[9:4]] && model_tag[w][a[9:4]] == a[63:10]) begin
				return w;
			end
		end
		return -1;
	endfunction

	function automatic icache_addr_pkg::addr_t pool_addr(input int t, input int i,
		input logic [1:0] w);
		return {tag_pool[t], index_pool[i], w, 2'b00};
	endfunction

	task automatic fail_run();
		$display("sim failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_eq(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			$display("Fail %s expected %h actual %h", name, expected, actual);
			fail_run();
		end
	endtask

	task automatic scan_assertions();
		if (u_icache_top.u_icache_props.req_errs != 0 ||
			u_icache_top.u_icache_props.victim_errs != 0 ||
			u_icache_top.u_icache_props.hit_errs != 0) begin
			$display("A bound assertion on the cache fired");
			fail_run();
		end
	endtask

	// One clock cycle of drive, falling-edge check and model update
	task automatic step(input logic v, input logic f, input logic r,
		input icache_addr_pkg::addr_t a);
		int   way;
		logic take;
		@(posedge clk);
		valid    <= v;
		flush    <= f;
		ready_id <= r;
		addr     <= a;
		@(negedge clk);
		check_eq("ready", 64'(exp_ready), 64'(ready));
		if (exp_ready) begin
			check_eq("inst", 64'(exp_inst), 64'(inst));
		end
		take = v && r && !f;
		way  = model_way(a);
		check_eq("mem_req", 64'(take && (way < 0)), 64'(mem_req));
		if (take && way < 0) begin
			check_eq("mem_addr", {a[63:4], 4'h0}, mem_addr);
		end
		scan_assertions();
		if (r) begin
			exp_ready = take;
			if (take) begin
				exp_inst = word_at(a);
			end
		end
		if (take && way < 0) begin
			model_tag[model_ring][a[9:4]]   = a[63:10]; // Fill the ring's way
			model_valid[model_ring][a[9:4]] = 1'b1;
			miss_count++;
		end else if (take) begin
			hit_count++;
		end
		if (r && !f) begin
			model_ring = (model_ring + 1) % `ICACHE_WAYS;
		end
	endtask

	initial begin
		for (int i = 0; i < TIMEOUT_CYCLES; i++) begin
			@(posedge clk);
		end
		$display("Simulation ran past its cycle limit");
		fail_run();
	end

	initial begin
		logic [31:0]            rnd;
		int                     stall;
		logic                   held_ready;
		icache_data_pkg::inst_t held_inst;
		seed     = 32'h7417_05f0;
		rst      <= 1'b1;
		valid    <= 1'b0;
		flush    <= 1'b0;
		ready_id <= 1'b0;
		addr     <= '0;
		tag_pool   = '{54'h1, 54'h2a, 54'h1_3c45, 54'hab_0777,
			54'h2_8000_0000_0102, 54'h3_0000_0000_0055};
		index_pool = '{6'd0, 6'd7, 6'd33};
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			for (int s = 0; s < `ICACHE_SETS; s++) begin
				model_valid[w][s] = 1'b0;
			end
		end
		model_ring = 0;
		exp_ready  = 1'b0;
		exp_inst   = '0;
		hit_count  = 0;
		miss_count = 0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;

		// Cold cache, then miss, then hits in the same line
		step(1'b0, 1'b0, 1'b1, pool_addr(0, 0, 2'd0));
		check_eq("mem_req", 64'(0), 64'(mem_req));
		step(1'b1, 1'b0, 1'b1, pool_addr(0, 0, 2'd2));
		check_eq("mem_req", 64'(1), 64'(mem_req));
		step(1'b1, 1'b0, 1'b1, pool_addr(0, 0, 2'd3));
		check_eq("mem_req", 64'(0), 64'(mem_req));

		// Five tags at one set evict the first one
		for (int t = 0; t < 5; t++) begin
			step(1'b1, 1'b0, 1'b1, pool_addr(t, 1, 2'(t)));
		end
		for (int t = 1; t < 5; t++) begin
			step(1'b1, 1'b0, 1'b1, pool_addr(t, 1, 2'd0));
			check_eq("mem_req", 64'(0), 64'(mem_req));
		end
		step(1'b1, 1'b0, 1'b1, pool_addr(0, 1, 2'd1));
		check_eq("mem_req", 64'(1), 64'(mem_req));

		// Back-pressure holds the response
		step(1'b1, 1'b0, 1'b1, pool_addr(0, 0, 2'd1));
		stall = 2 + int'($unsigned($random(seed)) % 5);
		step(1'b1, 1'b0, 1'b0, pool_addr(2, 2, 2'd0));
		held_ready = 1'b1;
		held_inst  = word_at(pool_addr(0, 0, 2'd1));
		for (int i = 1; i < stall; i++) begin
			step(1'b1, 1'b0, 1'b0, pool_addr(i % 6, 2, 2'd1));
			check_eq("ready", 64'(held_ready), 64'(ready));
			check_eq("inst", 64'(held_inst), 64'(inst));
			check_eq("mem_req", 64'(0), 64'(mem_req));
		end
		step(1'b1, 1'b0, 1'b1, pool_addr(0, 0, 2'd2));
		step(1'b0, 1'b0, 1'b1, pool_addr(0, 0, 2'd0));

		// Flush drops the response but keeps the tags
		step(1'b1, 1'b1, 1'b1, pool_addr(0, 0, 2'd0));
		step(1'b1, 1'b0, 1'b1, pool_addr(0, 0, 2'd0));
		check_eq("ready", 64'(0), 64'(ready));
		check_eq("mem_req", 64'(0), 64'(mem_req));
		step(1'b0, 1'b0, 1'b1, pool_addr(0, 0, 2'd0));

		for (int i = 0; i < RANDOM_CYCLES; i++) begin
			rnd = $random(seed);
			step(rnd[1:0] != 2'b00, rnd[7:4] == 4'h0, rnd[10:8] != 3'b000,
				pool_addr(int'($unsigned($random(seed)) % 6), int'(rnd[13:12]) % 3,
				rnd[17:16]));
		end
		step(1'b0, 1'b0, 1'b1, pool_addr(0, 0, 2'd0));

		if (hit_count == 0 || miss_count == 0) begin
			$display("Traffic produced no hits or no misses");
			fail_run();
		end else begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

`default_nettype wire
